//--- rv_core_top.f
+incdir+logic
logic/rv_isa_pkg.sv
logic/core_pkg.sv
logic/dmem_if.sv
logic/decoder.sv
logic/regfile.sv
logic/alu.sv
logic/memory.sv
logic/apb_host_ctrl.sv
logic/cpu_core.sv
logic/rv_core_top.sv
bench/tb_rv_core_top.sv

//--- bench/tb_rv_core_top.sv
/*
  testbench for rv_core_top
  loads programs over apb, runs the core, checks results against a small isa model
*/
`timescale 1ns/1ps
`include "core_consts.svh"

module tb_rv_core_top;

  localparam int CLK_PERIOD = 8;
  // about four times what the tests take
  localparam int TIMEOUT_CYCLES = 4000;
  localparam int HALT_WAIT = 200;

  // rv32i major opcodes from the isa
  localparam logic [6:0] OPC_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_JAL   = 7'b1101111;
  localparam logic [6:0] OPC_JALR  = 7'b1100111;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;
  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;
  // opcode 1111111 is not defined
  localparam logic [31:0] UNDEF_WORD = 32'h0000_007f;

  typedef enum {
    M_ADDI, M_ADD, M_SUB, M_LUI, M_AUIPC, M_JAL, M_JALR, M_LW, M_SW, M_EBREAK, M_UNDEF
  } mnem_e;

  logic        clk;
  logic        rst_n;
  logic [11:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [31:0] pc;
  logic        halted;
  logic        illegal;

  // isa model state
  logic [31:0] mregs [32];
  logic [31:0] mmem [`MEM_WORDS];
  logic        touched [`MEM_WORDS];
  // program under construction
  logic [31:0] prog [64];
  logic [31:0] bpc;
  int          prog_len;
  logic [31:0] halt_pc;
  logic [31:0] lcg_state;
  int          cycle_count = 0;

  rv_core_top u_dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .pc      (pc),
    .halted  (halted),
    .illegal (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run();
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_eq(string name, logic [31:0] exp, logic [31:0] got);
    assert (got === exp) else begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
      abort_run();
    end
  endtask

  // run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, the tests did not finish", cycle_count);
      abort_run();
    end
  end

  // zero wait state slave
  assert property (@(posedge clk) disable iff (!rst_n) pready) else begin
    $display("Mismatch at %0t: pready expected 1 got %b", $time, pready);
    abort_run();
  end

  // illegal only ever seen together with halt
  assert property (@(posedge clk) disable iff (!rst_n) illegal |-> halted) else begin
    $display("Mismatch at %0t: halted expected 1 got %b", $time, halted);
    abort_run();
  end

  // host data writes never make the core halt
  assert property (@(posedge clk) disable iff (!rst_n)
    (psel && penable && pwrite && paddr != `APB_CTRL_ADDR) |=>
    !$rose(halted) ##1 !$rose(halted)) else begin
    $display("halted rose right after an accepted host memory write at %0t", $time);
    abort_run();
  end

  // lcg with halves swapped so the low bits vary well
  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  // ctrl read layout: run, halted, illegal
  function automatic logic [31:0] status_word(core_pkg::run_state_e st, logic ill);
    return {29'b0, ill, st == core_pkg::ST_HALT, st == core_pkg::ST_RUN};
  endfunction

  function automatic logic [11:0] window_addr(int idx);
    return `APB_MEM_BASE + 12'(idx * 4);
  endfunction

  task automatic apb_write(logic [11:0] addr, logic [31:0] data, output logic err);
    // setup
    @(negedge clk);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    // access
    @(negedge clk);
    penable = 1'b1;
    #(CLK_PERIOD / 4);
    err = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(logic [11:0] addr, output logic [31:0] data, output logic err);
    @(negedge clk);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    // prdata was captured at the end of setup
    #(CLK_PERIOD / 4);
    data = prdata;
    err  = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_ok(logic [11:0] addr, logic [31:0] data);
    logic err;
    apb_write(addr, data, err);
    check_eq("pslverr", 0, err);
  endtask

  task automatic expect_read(logic [11:0] addr, logic [31:0] exp, string name);
    logic [31:0] data;
    logic        err;
    apb_read(addr, data, err);
    check_eq("pslverr", 0, err);
    check_eq(name, exp, data);
  endtask

  task automatic check_memory();
    for (int i = 0; i < `MEM_WORDS; i++) begin
      if (touched[i]) begin
        expect_read(window_addr(i), mmem[i], $sformatf("mem[%0d]", i));
      end
    end
  endtask

  task automatic new_program();
    bpc      = '0;
    prog_len = 0;
  endtask

  // encode one instruction and apply it to the model
  task automatic assemble(mnem_e m, int rd, int rs1, int rs2, logic [31:0] imm);
    logic [4:0]  d;
    logic [4:0]  s1;
    logic [4:0]  s2;
    logic [31:0] word;
    logic [31:0] simm;
    logic [31:0] addr;
    logic [31:0] wb;
    logic [31:0] target;
    logic        wr;
    d      = rd[4:0];
    s1     = rs1[4:0];
    s2     = rs2[4:0];
    simm   = {{20{imm[11]}}, imm[11:0]};
    word   = '0;
    wb     = '0;
    wr     = 1'b0;
    target = '0;
    case (m)
      M_ADDI: begin
        word = {imm[11:0], s1, 3'b000, d, OPC_IMM};
        wb   = mregs[rs1] + simm;
        wr   = 1'b1;
      end
      M_ADD: begin
        word = {7'b0000000, s2, s1, 3'b000, d, OPC_OP};
        wb   = mregs[rs1] + mregs[rs2];
        wr   = 1'b1;
      end
      M_SUB: begin
        word = {7'b0100000, s2, s1, 3'b000, d, OPC_OP};
        wb   = mregs[rs1] - mregs[rs2];
        wr   = 1'b1;
      end
      M_LUI: begin
        word = {imm[19:0], d, OPC_LUI};
        wb   = {imm[19:0], 12'b0};
        wr   = 1'b1;
      end
      M_AUIPC: begin
        word = {imm[19:0], d, OPC_AUIPC};
        wb   = bpc + {imm[19:0], 12'b0};
        wr   = 1'b1;
      end
      M_JAL: begin
        // forward offset in imm[20:0]
        word   = {imm[20], imm[10:1], imm[11], imm[19:12], d, OPC_JAL};
        wb     = bpc + 32'd4;
        wr     = 1'b1;
        target = bpc + imm;
      end
      M_JALR: begin
        word   = {imm[11:0], s1, 3'b000, d, OPC_JALR};
        wb     = bpc + 32'd4;
        wr     = 1'b1;
        target = (mregs[rs1] + simm) & ~32'd1;
      end
      M_LW: begin
        word = {imm[11:0], s1, 3'b010, d, OPC_LOAD};
        addr = mregs[rs1] + simm;
        wb   = mmem[addr[9:2]];
        wr   = 1'b1;
      end
      M_SW: begin
        word = {imm[11:5], s2, s1, 3'b010, imm[4:0], OPC_STORE};
        addr = mregs[rs1] + simm;
        mmem[addr[9:2]]    = mregs[rs2];
        touched[addr[9:2]] = 1'b1;
      end
      M_EBREAK: begin
        word    = EBREAK_WORD;
        halt_pc = bpc;
      end
      default: begin
        word    = UNDEF_WORD;
        halt_pc = bpc;
      end
    endcase
    if (wr && rd != 0) begin
      mregs[rd] = wb;
    end
    prog[bpc[7:2]] = word;
    bpc            = bpc + 32'd4;
    // skipped slots hold zero words, which halt as illegal if reached
    while (bpc < target) begin
      prog[bpc[7:2]] = '0;
      bpc            = bpc + 32'd4;
    end
    prog_len = int'(bpc >> 2);
  endtask

  task automatic load_and_run();
    for (int i = 0; i < prog_len; i++) begin
      write_ok(window_addr(i), prog[i]);
    end
    write_ok(`APB_CTRL_ADDR, 32'h1);
  endtask

  task automatic wait_for_halt();
    int n;
    n = 0;
    while (!halted && n < HALT_WAIT) begin
      @(negedge clk);
      n++;
    end
    if (!halted) begin
      $display("core did not halt within %0d cycles, pc is %h", HALT_WAIT, pc);
      abort_run();
    end
  endtask

  initial begin
    logic [31:0] rnd;
    logic [31:0] data;
    logic        err;
    rst_n     = 1'b0;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    lcg_state = 32'd27573;
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    for (int i = 0; i < `MEM_WORDS; i++) begin
      touched[i] = 1'b0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // reset values
    @(negedge clk);
    check_eq("halted", 0, halted);
    check_eq("illegal", 0, illegal);
    check_eq("pslverr", 0, pslverr);
    check_eq("pc", `PC_RST, pc);
    check_eq("prdata", 0, prdata);
    expect_read(`APB_CTRL_ADDR, status_word(core_pkg::ST_IDLE, 1'b0), "ctrl");
    expect_read(`APB_PC_ADDR, `PC_RST, "pc register");

    // host window write and readback
    for (int i = 200; i < 208; i++) begin
      rnd = next_random();
      write_ok(window_addr(i), rnd);
      mmem[i]    = rnd;
      touched[i] = 1'b1;
    end
    check_memory();
    // unmapped addresses
    apb_read(12'h008, data, err);
    check_eq("pslverr", 1, err);
    apb_read(12'h800, data, err);
    check_eq("pslverr", 1, err);
    apb_write(12'h100, 32'hdead_beef, err);
    check_eq("pslverr", 1, err);

    // arithmetic with an addi chain through the previous register
    new_program();
    for (int r = 1; r <= 6; r++) begin
      rnd = next_random();
      assemble(M_ADDI, r, r - 1, 0, rnd);
    end
    assemble(M_ADD, 7, 1, 2, 0);
    assemble(M_SUB, 8, 3, 7, 0);
    // negate through x0
    assemble(M_SUB, 9, 0, 6, 0);
    assemble(M_LUI, 10, 0, 0, next_random());
    assemble(M_ADDI, 11, 10, 0, next_random());
    assemble(M_AUIPC, 12, 0, 0, next_random());
    for (int r = 1; r <= 12; r++) begin
      assemble(M_SW, 0, 0, r, 32'h200 + 4 * (r - 1));
    end
    assemble(M_EBREAK, 0, 0, 0, 0);
    load_and_run();
    wait_for_halt();
    check_eq("illegal", 0, illegal);
    check_eq("pc", halt_pc, pc);
    expect_read(`APB_CTRL_ADDR, status_word(core_pkg::ST_HALT, 1'b0), "ctrl");
    expect_read(`APB_PC_ADDR, halt_pc, "pc register");
    check_memory();

    // jumps and loads
    new_program();
    assemble(M_ADDI, 1, 0, 0, next_random());
    assemble(M_JAL, 2, 0, 0, 8);
    assemble(M_AUIPC, 5, 0, 0, 0);
    // odd offset clears bit 0 of the target
    assemble(M_JALR, 6, 5, 0, 13);
    assemble(M_SW, 0, 0, 2, 32'h240);
    assemble(M_SW, 0, 0, 6, 32'h244);
    assemble(M_SW, 0, 0, 1, 32'h248);
    assemble(M_LW, 7, 0, 0, 32'h248);
    assemble(M_SW, 0, 0, 7, 32'h24c);
    // load and store through a base register
    assemble(M_ADDI, 8, 0, 0, 32'h240);
    assemble(M_LW, 9, 8, 0, 4);
    assemble(M_SW, 0, 8, 9, 16);
    assemble(M_EBREAK, 0, 0, 0, 0);
    load_and_run();
    wait_for_halt();
    check_eq("illegal", 0, illegal);
    check_eq("pc", halt_pc, pc);
    check_memory();

    // undefined opcode
    new_program();
    assemble(M_ADDI, 1, 0, 0, next_random());
    assemble(M_SW, 0, 0, 1, 32'h260);
    assemble(M_UNDEF, 0, 0, 0, 0);
    load_and_run();
    wait_for_halt();
    check_eq("illegal", 1, illegal);
    check_eq("pc", halt_pc, pc);
    expect_read(`APB_CTRL_ADDR, status_word(core_pkg::ST_HALT, 1'b1), "ctrl");
    check_memory();
    // patch in an ebreak, restart clears the flag
    write_ok(window_addr(int'(halt_pc >> 2)), EBREAK_WORD);
    write_ok(`APB_CTRL_ADDR, 32'h1);
    check_eq("illegal", 0, illegal);
    wait_for_halt();
    check_eq("illegal", 0, illegal);
    check_eq("pc", halt_pc, pc);
    expect_read(`APB_CTRL_ADDR, status_word(core_pkg::ST_HALT, 1'b0), "ctrl");

    // host write while running is refused
    new_program();
    // spin on one jal
    assemble(M_JAL, 0, 0, 0, 0);
    load_and_run();
    mmem[0]    = prog[0];
    touched[0] = 1'b1;
    expect_read(`APB_CTRL_ADDR, status_word(core_pkg::ST_RUN, 1'b0), "ctrl");
    // an ebreak over the spinning jal would halt the core if it got through
    apb_write(window_addr(0), EBREAK_WORD, err);
    check_eq("pslverr", 1, err);
    check_eq("halted", 0, halted);
    // forced halt from the host
    write_ok(`APB_CTRL_ADDR, 32'h2);
    check_eq("halted", 1, halted);
    check_eq("illegal", 0, illegal);
    check_eq("pc", 0, pc);
    expect_read(`APB_CTRL_ADDR, status_word(core_pkg::ST_HALT, 1'b0), "ctrl");
    check_memory();

    $display("Test OK");
    $finish;
  end

endmodule

//--- logic/rv_core_top.sv
/*
  rv32i core with apb host port
  host loads memory, starts the core and reads status and results
*/
`timescale 1ns/1ps
`include "core_consts.svh"

module rv_core_top (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [11:0]      paddr,
  input  logic             psel,
  input  logic             penable,
  input  logic             pwrite,
  input  logic [31:0]      pwdata,
  output logic [31:0]      prdata,
  output logic             pready,
  output logic             pslverr,
  output logic [`XLEN-1:0] pc,
  output logic             halted,
  output logic             illegal
);

  logic [31:0]        inst;
  logic               run;
  logic               halt_req;
  logic               illegal_req;
  logic [`MEM_AW-1:0] host_addr;
  logic [`XLEN-1:0]   host_wdata;
  logic               host_wen;
  logic [`XLEN-1:0]   host_rdata;

  // core to memory data path
  dmem_if u_dmem_if ();

  apb_host_ctrl u_apb_host_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .run         (run),
    .halted      (halted),
    .illegal     (illegal),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .host_wen    (host_wen),
    .host_rdata  (host_rdata),
    .pc          (pc),
    .halt_req    (halt_req),
    .illegal_req (illegal_req)
  );

  memory u_memory (
    .clk        (clk),
    .pc         (pc),
    .inst       (inst),
    .dmem       (u_dmem_if.mem),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_wen   (host_wen),
    .host_rdata (host_rdata)
  );

  cpu_core u_cpu_core (
    .clk         (clk),
    .rst_n       (rst_n),
    .run         (run),
    .inst        (inst),
    .pc          (pc),
    .halt_req    (halt_req),
    .illegal_req (illegal_req),
    .dmem        (u_dmem_if.core)
  );

endmodule

//--- logic/cpu_core.sv
/*
  single cycle rv32i core
  pc register, operand and write-back muxes around decoder, regfile and alu
*/
`timescale 1ns/1ps
`include "core_consts.svh"

module cpu_core (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             run,
  input  logic [31:0]      inst,
  output logic [`XLEN-1:0] pc,
  output logic             halt_req,
  output logic             illegal_req,
  dmem_if.core             dmem
);

  logic [4:0]        rd;
  logic [4:0]        rs1;
  logic [4:0]        rs2;
  logic [`XLEN-1:0]  imm;
  rv_isa_pkg::ctrl_t ctrl;
  logic [`XLEN-1:0]  rdata_a;
  logic [`XLEN-1:0]  rdata_b;
  logic [`XLEN-1:0]  op_a;
  logic [`XLEN-1:0]  op_b;
  logic [`XLEN-1:0]  alu_y;
  logic [`XLEN-1:0]  wb_data;
  logic [`XLEN-1:0]  pc_q;
  logic [`XLEN-1:0]  pc_plus4;
  logic [`XLEN-1:0]  pc_next;
  logic              run_d;
  logic              halt;
  logic              commit;

  decoder u_decoder (
    .inst (inst),
    .rd   (rd),
    .rs1  (rs1),
    .rs2  (rs2),
    .imm  (imm),
    .ctrl (ctrl)
  );

  // first run cycle fetches from the reset pc
  assign pc       = (run && !run_d) ? `PC_RST : pc_q;
  assign pc_plus4 = pc + 32'd4;

  // ebreak and illegal retire without side effects
  assign halt        = ctrl.is_ebreak || ctrl.illegal;
  assign commit      = run && !halt;
  assign halt_req    = run && halt;
  assign illegal_req = run && ctrl.illegal;

  // operand muxes
  assign op_a = ctrl.use_pc ? pc : rdata_a;
  assign op_b = ctrl.use_imm ? imm : rdata_b;

  alu u_alu (
    .a  (op_a),
    .b  (op_b),
    .op (ctrl.alu_op),
    .y  (alu_y)
  );

  // jumps link pc + 4, loads take memory data
  always_comb begin
    if (ctrl.is_jal || ctrl.is_jalr) begin
      wb_data = pc_plus4;
    end else if (ctrl.mem_ren) begin
      wb_data = dmem.rdata;
    end else begin
      wb_data = alu_y;
    end
  end

  regfile u_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .wen     (ctrl.reg_wen && commit),
    .waddr   (rd),
    .wdata   (wb_data),
    .raddr_a (rs1),
    .raddr_b (rs2),
    .rdata_a (rdata_a),
    .rdata_b (rdata_b)
  );

  // data port, address from rs1 + imm
  assign dmem.addr  = alu_y;
  assign dmem.wdata = rdata_b;
  assign dmem.wen   = ctrl.mem_wen && commit;
  assign dmem.ren   = ctrl.mem_ren && run;

  // next pc, halting instruction keeps its own address
  always_comb begin
    if (halt) begin
      pc_next = pc;
    end else if (ctrl.is_jal) begin
      pc_next = pc + imm;
    end else if (ctrl.is_jalr) begin
      pc_next = {alu_y[`XLEN-1:1], 1'b0};
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q  <= `PC_RST;
      run_d <= 1'b0;
    end else begin
      run_d <= run;
      if (run) begin
        pc_q <= pc_next;
      end
    end
  end

endmodule

//--- logic/apb_host_ctrl.sv
/*
  apb host controller
  zero wait state slave, run/halt state machine, host window into memory
*/
`timescale 1ns/1ps
`include "core_consts.svh"

module apb_host_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [11:0]        paddr,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [31:0]        pwdata,
  output logic [31:0]        prdata,
  output logic               pready,
  output logic               pslverr,
  output logic               run,
  output logic               halted,
  output logic               illegal,
  output logic [`MEM_AW-1:0] host_addr,
  output logic [`XLEN-1:0]   host_wdata,
  output logic               host_wen,
  input  logic [`XLEN-1:0]   host_rdata,
  input  logic [`XLEN-1:0]   pc,
  input  logic               halt_req,
  input  logic               illegal_req
);

  core_pkg::run_state_e state;
  core_pkg::run_state_e state_nxt;
  core_pkg::apb_sel_e   sel;
  logic                 access;
  logic                 ctrl_wr;
  logic [31:0]          rd_data;

  // address decode
  always_comb begin
    if (paddr == `APB_CTRL_ADDR) begin
      sel = core_pkg::SEL_CTRL;
    end else if (paddr == `APB_PC_ADDR) begin
      sel = core_pkg::SEL_PC;
    end else if (paddr >= `APB_MEM_BASE && paddr < (`APB_MEM_BASE + 4 * `MEM_WORDS)) begin
      sel = core_pkg::SEL_MEM;
    end else begin
      sel = core_pkg::SEL_NONE;
    end
  end

  // transfers complete in the access phase
  assign access  = psel && penable;
  assign ctrl_wr = access && pwrite && sel == core_pkg::SEL_CTRL;
  assign pready  = 1'b1;

  // unmapped address, or a memory write while the core runs
  assign pslverr = access && (sel == core_pkg::SEL_NONE ||
                   (sel == core_pkg::SEL_MEM && pwrite && state == core_pkg::ST_RUN));

  // host memory window, blocked during run
  assign host_addr  = paddr[`MEM_AW+1:2];
  assign host_wdata = pwdata;
  assign host_wen   = access && pwrite && sel == core_pkg::SEL_MEM &&
                      state != core_pkg::ST_RUN;

  // ctrl bit 1 forces halt, bit 0 starts from idle or halt
  always_comb begin
    state_nxt = state;
    case (state)
      core_pkg::ST_RUN: begin
        if ((ctrl_wr && pwdata[1]) || halt_req) begin
          state_nxt = core_pkg::ST_HALT;
        end
      end
      default: begin
        if (ctrl_wr && pwdata[1]) begin
          state_nxt = core_pkg::ST_HALT;
        end else if (ctrl_wr && pwdata[0]) begin
          state_nxt = core_pkg::ST_RUN;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= core_pkg::ST_IDLE;
      illegal <= 1'b0;
    end else begin
      state <= state_nxt;
      // sticky until the next start
      if (state != core_pkg::ST_RUN && state_nxt == core_pkg::ST_RUN) begin
        illegal <= 1'b0;
      end else if (state == core_pkg::ST_RUN && illegal_req) begin
        illegal <= 1'b1;
      end
    end
  end

  assign run    = state == core_pkg::ST_RUN;
  assign halted = state == core_pkg::ST_HALT;

  // read mux
  always_comb begin
    case (sel)
      core_pkg::SEL_CTRL: rd_data = {29'b0, illegal, halted, run};
      core_pkg::SEL_PC:   rd_data = pc;
      core_pkg::SEL_MEM:  rd_data = host_rdata;
      default:            rd_data = '0;
    endcase
  end

  // read data captured in setup, valid through the access phase
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prdata <= '0;
    end else if (psel && !penable && !pwrite) begin
      prdata <= rd_data;
    end
  end

endmodule

//--- logic/memory.sv
/*
  unified word memory
  fetch port, core data port and host port on one array
*/
`timescale 1ns/1ps
`include "core_consts.svh"

module memory (
  input  logic              clk,
  input  logic [`XLEN-1:0]  pc,
  output logic [31:0]       inst,
  dmem_if.mem               dmem,
  input  logic [`MEM_AW-1:0] host_addr,
  input  logic [`XLEN-1:0]  host_wdata,
  input  logic              host_wen,
  output logic [`XLEN-1:0]  host_rdata
);

  // instructions and data share this array
  logic [`XLEN-1:0] mem [`MEM_WORDS];

  logic [`MEM_AW-1:0] fetch_idx;
  logic [`MEM_AW-1:0] data_idx;

  // byte address to word index
  assign fetch_idx = pc[`MEM_AW+1:2];
  assign data_idx  = dmem.addr[`MEM_AW+1:2];

  // all reads combinational
  assign inst       = mem[fetch_idx];
  assign dmem.rdata = dmem.ren ? mem[data_idx] : '0;
  assign host_rdata = mem[host_addr];

  // host writes only outside run, so the two ports never collide
  always_ff @(posedge clk) begin
    if (dmem.wen) begin
      mem[data_idx] <= dmem.wdata;
    end
    if (host_wen) begin
      mem[host_addr] <= host_wdata;
    end
  end

endmodule

//--- logic/alu.sv
/*
  alu
  add, subtract or pass operand b through
*/
`timescale 1ns/1ps
`include "core_consts.svh"

module alu (
  input  logic [`XLEN-1:0]  a,
  input  logic [`XLEN-1:0]  b,
  input  rv_isa_pkg::alu_op_e op,
  output logic [`XLEN-1:0]  y
);

  always_comb begin
    case (op)
      rv_isa_pkg::ALU_ADD:    y = a + b;
      rv_isa_pkg::ALU_SUB:    y = a - b;
      // lui, immediate goes straight to rd
      rv_isa_pkg::ALU_PASS_B: y = b;
      default:                y = '0;
    endcase
  end

endmodule

//--- logic/regfile.sv
/*
  32 x 32 register file
  two async read ports, one sync write port, x0 stays zero
*/
`timescale 1ns/1ps
`include "core_consts.svh"

module regfile (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             wen,
  input  logic [4:0]       waddr,
  input  logic [`XLEN-1:0] wdata,
  input  logic [4:0]       raddr_a,
  input  logic [4:0]       raddr_b,
  output logic [`XLEN-1:0] rdata_a,
  output logic [`XLEN-1:0] rdata_b
);

  logic [`XLEN-1:0] regs [32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != 5'd0) begin
      // x0 writes dropped
      regs[waddr] <= wdata;
    end
  end

  assign rdata_a = regs[raddr_a];
  assign rdata_b = regs[raddr_b];

endmodule

//--- logic/decoder.sv
/*
  rv32i decoder
  splits the instruction word into register ids, immediate and control
*/
`timescale 1ns/1ps
`include "core_consts.svh"

module decoder (
  input  logic [31:0]        inst,
  output logic [4:0]         rd,
  output logic [4:0]         rs1,
  output logic [4:0]         rs2,
  output logic [`XLEN-1:0]   imm,
  output rv_isa_pkg::ctrl_t  ctrl
);

  rv_isa_pkg::opcode_e opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`XLEN-1:0]    imm_i;
  logic [`XLEN-1:0]    imm_s;
  logic [`XLEN-1:0]    imm_u;
  logic [`XLEN-1:0]    imm_j;

  assign opcode = rv_isa_pkg::opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // register fields sit at fixed positions
  assign rd  = inst[11:7];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  // immediate formats, sign extended from bit 31
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    ctrl        = '0;
    ctrl.alu_op = rv_isa_pkg::ALU_ADD;
    imm         = imm_i;
    case (opcode)
      rv_isa_pkg::OP_IMM: begin
        // addi only
        ctrl.use_imm = 1'b1;
        ctrl.reg_wen = funct3 == 3'b000;
        ctrl.illegal = funct3 != 3'b000;
      end
      rv_isa_pkg::OP: begin
        // add and sub share funct3 000, funct7 picks
        if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
          ctrl.reg_wen = 1'b1;
        end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
          ctrl.alu_op  = rv_isa_pkg::ALU_SUB;
          ctrl.reg_wen = 1'b1;
        end else begin
          ctrl.illegal = 1'b1;
        end
      end
      rv_isa_pkg::LUI: begin
        imm          = imm_u;
        ctrl.alu_op  = rv_isa_pkg::ALU_PASS_B;
        ctrl.use_imm = 1'b1;
        ctrl.reg_wen = 1'b1;
      end
      rv_isa_pkg::AUIPC: begin
        imm          = imm_u;
        ctrl.use_imm = 1'b1;
        ctrl.use_pc  = 1'b1;
        ctrl.reg_wen = 1'b1;
      end
      rv_isa_pkg::JAL: begin
        imm          = imm_j;
        ctrl.is_jal  = 1'b1;
        ctrl.reg_wen = 1'b1;
      end
      rv_isa_pkg::JALR: begin
        // target rs1 + imm comes out of the alu
        ctrl.use_imm = 1'b1;
        ctrl.is_jalr = funct3 == 3'b000;
        ctrl.reg_wen = funct3 == 3'b000;
        ctrl.illegal = funct3 != 3'b000;
      end
      rv_isa_pkg::LOAD: begin
        // word loads only
        ctrl.use_imm = 1'b1;
        ctrl.mem_ren = funct3 == 3'b010;
        ctrl.reg_wen = funct3 == 3'b010;
        ctrl.illegal = funct3 != 3'b010;
      end
      rv_isa_pkg::STORE: begin
        imm          = imm_s;
        ctrl.use_imm = 1'b1;
        ctrl.mem_wen = funct3 == 3'b010;
        ctrl.illegal = funct3 != 3'b010;
      end
      rv_isa_pkg::SYSTEM: begin
        // ebreak is one exact encoding, the rest of system is out
        ctrl.is_ebreak = inst == 32'h0010_0073;
        ctrl.illegal   = inst != 32'h0010_0073;
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

endmodule

//--- logic/dmem_if.sv
/*
  data memory port of the core
  combinational read, write on the rising edge
*/
`timescale 1ns/1ps
`include "core_consts.svh"

interface dmem_if;
  // byte address from the alu
  logic [`XLEN-1:0] addr;
  logic [`XLEN-1:0] wdata;
  logic             wen;
  logic             ren;
  logic [`XLEN-1:0] rdata;

  modport core (output addr, output wdata, output wen, output ren, input rdata);
  modport mem (input addr, input wdata, input wen, input ren, output rdata);
endinterface

//--- logic/core_pkg.sv
/*
  core level types
  host run state and apb register select
*/
package core_pkg;

  // core run state as seen by the host
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_RUN  = 2'd1,
    ST_HALT = 2'd2
  } run_state_e;

  // decoded apb target
  typedef enum logic [1:0] {
    SEL_CTRL = 2'd0,
    SEL_PC   = 2'd1,
    SEL_MEM  = 2'd2,
    SEL_NONE = 2'd3
  } apb_sel_e;

endpackage

//--- logic/rv_isa_pkg.sv
/*
  rv32i isa types
  major opcodes, alu operations and the decoded control word
*/
package rv_isa_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    SYSTEM = 7'b1110011
  } opcode_e;

  // alu operations
  // pass-b serves lui
  typedef enum logic [1:0] {
    ALU_ADD    = 2'd0,
    ALU_SUB    = 2'd1,
    ALU_PASS_B = 2'd2
  } alu_op_e;

  // decoded control, one per instruction
  typedef struct packed {
    alu_op_e alu_op;
    logic    use_imm;
    // operand a from pc (auipc)
    logic    use_pc;
    logic    reg_wen;
    logic    mem_wen;
    logic    mem_ren;
    logic    is_jal;
    logic    is_jalr;
    logic    is_ebreak;
    logic    illegal;
  } ctrl_t;

endpackage

//--- logic/core_consts.svh
/*
  core constants
  data width, reset pc, memory depth and apb address map
*/
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// data path width
`define XLEN 32
// pc after reset and on start
`define PC_RST 32'h0000_0000

// word memory, byte address bits 9:2 pick a word
`define MEM_WORDS 256
`define MEM_AW 8

// apb map
`define APB_CTRL_ADDR 12'h000
`define APB_PC_ADDR 12'h004
`define APB_MEM_BASE 12'h400

`endif
